/* filelist.f */
+incdir+src
src/sifhPkg.sv
src/frameSequencer.sv
src/sampleFilter.sv
src/binHistogram.sv
src/peakTracker.sv
src/windowCalc.sv
src/sifhTop.sv
bench/sifhChecker.sv
bench/sifhTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = sifhTb
FILELIST  = filelist.f
OBJDIR    = obj_dir
LOG       = sim.log
FAIL_MSG  = ERRORS FOUND
PASS_MSG  = NO ERRORS

SIM  = $(OBJDIR)/V$(TOP)
SRCS = $(shell grep -v '^+' $(FILELIST))
HDRS = $(wildcard src/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation ended without a verdict"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* bench/sifhTb.sv */
//**********************************************************
// SiFH peak finder testbench
//**********************************************************

`timescale 1ns/1ps

`include "sifh_params.svh"

module sifhTb import sifhPkg::*; ();

    localparam int ROWS       = 6;
    localparam int CLK_PERIOD = 4;
    localparam int SAMPLES    = `SIFH_PIXELS * `SIFH_DATA_NUM * `SIFH_ACQ_NUM;
    // three cycles per sample covers gaps, drains and the reset row
    localparam int TIMEOUT_CYCLES = ROWS * 2 * SAMPLES * 3 + 500;

    //**********************************************************
    // stimulus table, one row per frame
    //**********************************************************

    // true peak timestamp per pixel
    localparam stampT PEAK_TAB [ROWS][`SIFH_PIXELS] = '{
        '{8'h03, 8'h45, 8'hA7, 8'hF5},
        '{8'h00, 8'h0F, 8'h12, 8'hF7},
        '{8'h20, 8'h60, 8'h90, 8'hD0},
        '{8'h33, 8'h77, 8'h84, 8'hC6},
        '{8'h08, 8'hE8, 8'h5C, 8'hFC},
        '{8'h70, 8'h71, 8'h72, 8'h73}
    };

    // jitter mask, zero means every photon lands on the peak
    localparam stampT MASK_TAB [ROWS][`SIFH_PIXELS] = '{
        '{8'h00, 8'h00, 8'h00, 8'h00},
        '{8'h00, 8'h00, 8'h00, 8'h00},
        '{8'h03, 8'h07, 8'h0F, 8'h1F},
        '{8'h00, 8'h00, 8'h00, 8'h00},
        '{8'h01, 8'h3F, 8'h07, 8'h03},
        '{8'h0F, 8'h0F, 8'h0F, 8'h0F}
    };

    // expected result, jittered pixels rely on the model only
    localparam stampT EXP_TAB [ROWS][`SIFH_PIXELS] = '{
        '{8'h03, 8'h45, 8'hA7, 8'hF5},
        '{8'h00, 8'h0F, 8'h12, 8'hF7},
        '{8'h00, 8'h00, 8'h00, 8'h00},
        '{8'h33, 8'h77, 8'h84, 8'hC6},
        '{8'h00, 8'h00, 8'h00, 8'h00},
        '{8'h00, 8'h00, 8'h00, 8'h00}
    };

    // fine samples played before a mid-frame reset, 0 for none
    localparam int ABORT_TAB [ROWS] = '{0, 0, 0, 50, 0, 0};

    logic                     clk;
    logic                     combin_res;
    logic                     wrEn;
    stampT                    data;
    logic                     busy;
    logic                     finePass;
    logic                     resultValid;
    stampT [`SIFH_PIXELS-1:0] result;

    stampT [`SIFH_PIXELS-1:0] expResult;
    logic  [`SIFH_PIXELS-1:0] expKnown;
    int                       chkErrors;
    int                       chkResults;
    int                       tbErrors;
    logic [15:0]              lfsrState = 16'd25784;

    sifhTop dut_i (
        .clk         (clk),
        .combin_res  (combin_res),
        .wrEn        (wrEn),
        .data        (data),
        .busy        (busy),
        .finePass    (finePass),
        .resultValid (resultValid),
        .result      (result)
    );

    sifhChecker chk_i (
        .clk         (clk),
        .combin_res  (combin_res),
        .wrEn        (wrEn),
        .data        (data),
        .busy        (busy),
        .finePass    (finePass),
        .resultValid (resultValid),
        .result      (result),
        .expResult   (expResult),
        .expKnown    (expKnown),
        .errors      (chkErrors),
        .results     (chkResults)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //**********************************************************
    // random bits
    //**********************************************************

    // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsrBit();
        logic outBit;
        outBit    = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) begin
            lfsrState = lfsrState ^ 16'hB400;
        end
        return outBit;
    endfunction

    // one step per bit taken
    function automatic logic [7:0] randBits(int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[6:0], lfsrBit()};
        end
        return v;
    endfunction

    // pixel-major samples with random gaps and no-photon stamps
    task automatic playSamples(int row, int count);
        int n;
        int pix;
        n = 0;
        while (n < count) begin
            @(posedge clk);
            if (randBits(2) == 8'd0) begin
                wrEn <= 1'b0;
                data <= randBits(8);
            end else begin
                pix  = (n / `SIFH_DATA_NUM) % `SIFH_PIXELS;
                wrEn <= 1'b1;
                if (randBits(3) == 8'd0) begin
                    data <= '1;
                end else begin
                    data <= PEAK_TAB[row][pix] + (randBits(8) & MASK_TAB[row][pix]);
                end
                n++;
            end
        end
    endtask

    // strobes junk while busy, none that reaches the edge where busy falls
    task automatic drainPass();
        int cycles;
        cycles = 0;
        @(posedge clk);
        wrEn <= 1'b0;
        @(posedge clk);
        while (busy) begin
            cycles++;
            wrEn <= (cycles < `SIFH_DRAIN);
            data <= randBits(8);
            @(posedge clk);
        end
        wrEn <= 1'b0;
    endtask

    task automatic midFrameReset();
        @(posedge clk);
        combin_res <= 1'b0;
        wrEn       <= 1'b0;
        repeat (3) @(posedge clk);
        combin_res <= 1'b1;
    endtask

    //**********************************************************
    // main sequence
    //**********************************************************

    initial begin
        combin_res = 1'b0;
        wrEn       = 1'b0;
        data       = '0;
        expResult  = '0;
        expKnown   = '0;
        tbErrors   = 0;
        repeat (10) @(posedge clk);
        combin_res <= 1'b1;
        for (int r = 0; r < ROWS; r++) begin
            for (int p = 0; p < `SIFH_PIXELS; p++) begin
                expResult[p] <= EXP_TAB[r][p];
                expKnown[p]  <= (MASK_TAB[r][p] == 8'h00);
            end
            // abandoned frame, the DUT must restart with a coarse pass
            if (ABORT_TAB[r] != 0) begin
                playSamples(r, SAMPLES);
                drainPass();
                playSamples(r, ABORT_TAB[r]);
                midFrameReset();
            end
            playSamples(r, SAMPLES);
            drainPass();
            playSamples(r, SAMPLES);
            drainPass();
        end
        repeat (4) @(posedge clk);
        if (chkResults != ROWS) begin
            $display("wrong number of results: %0d for %0d frames", chkResults, ROWS);
            tbErrors++;
        end
        $display("checked %0d frames: %0d checker errors, %0d bench errors",
                 ROWS, chkErrors, tbErrors);
        if (chkErrors + tbErrors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* bench/sifhChecker.sv */
//**********************************************************
// SiFH reference model and checker
//**********************************************************

`timescale 1ns/1ps

`include "sifh_params.svh"

module sifhChecker import sifhPkg::*; (
    input  logic                     clk,
    input  logic                     combin_res,
    input  logic                     wrEn,
    input  stampT                    data,
    input  logic                     busy,
    input  logic                     finePass,
    input  logic                     resultValid,
    input  stampT [`SIFH_PIXELS-1:0] result,
    input  stampT [`SIFH_PIXELS-1:0] expResult,
    input  logic  [`SIFH_PIXELS-1:0] expKnown,
    output int                       errors,
    output int                       results
);

    localparam int BINS    = 1 << `SIFH_NB;
    localparam int HALF    = BINS / 2;
    localparam int TH_MAX  = (1 << `SIFH_NP) - BINS;
    localparam int SAMPLES = `SIFH_PIXELS * `SIFH_DATA_NUM * `SIFH_ACQ_NUM;

    // model histograms and running peaks
    int histM   [`SIFH_PIXELS][BINS];
    int bestCnt [`SIFH_PIXELS];
    int bestBin [`SIFH_PIXELS];
    int thLowM  [`SIFH_PIXELS];
    int expM    [`SIFH_PIXELS];

    int   accepted;
    int   drainLeft;
    logic fineM;
    logic resultDue;
    int   errCnt = 0;
    int   resCnt = 0;

    assign errors  = errCnt;
    assign results = resCnt;

    // window lower edge, clamped into the timestamp range
    function automatic int windowEdge(int peak);
        int lowEdge;
        lowEdge = (peak << (`SIFH_NP - `SIFH_NB)) - HALF;
        if (lowEdge < 0) begin
            lowEdge = 0;
        end
        if (lowEdge > TH_MAX) begin
            lowEdge = TH_MAX;
        end
        return lowEdge;
    endfunction

    task automatic reportMismatch(string what, int got, int want);
        $display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, got, want);
        errCnt++;
    endtask

    task automatic clearModel();
        for (int p = 0; p < `SIFH_PIXELS; p++) begin
            for (int b = 0; b < BINS; b++) begin
                histM[p][b] = 0;
            end
            bestCnt[p] = 0;
            bestBin[p] = 0;
        end
    endtask

    //**********************************************************
    // per-sample model
    //**********************************************************

    task automatic countSample(stampT s);
        int pix;
        int b;
        pix = (accepted / `SIFH_DATA_NUM) % `SIFH_PIXELS;
        // no photon
        if (&s) begin
            return;
        end
        if (!fineM) begin
            b = int'(s) >> (`SIFH_NP - `SIFH_NB);
        end else begin
            b = int'(s) - thLowM[pix];
            // outside the fine window
            if (b < 0 || b >= BINS) begin
                return;
            end
        end
        histM[pix][b]++;
        // first bin to reach a new maximum wins
        if (histM[pix][b] > bestCnt[pix]) begin
            bestCnt[pix] = histM[pix][b];
            bestBin[pix] = b;
        end
    endtask

    task automatic endPass();
        if (!fineM) begin
            for (int p = 0; p < `SIFH_PIXELS; p++) begin
                thLowM[p] = windowEdge(bestBin[p]);
            end
        end else begin
            for (int p = 0; p < `SIFH_PIXELS; p++) begin
                expM[p] = thLowM[p] + bestBin[p];
            end
            resultDue = 1'b1;
        end
        clearModel();
        fineM = !fineM;
    endtask

    task automatic checkOutputs();
        if (busy !== (drainLeft != 0)) begin
            reportMismatch("busy", int'(busy), int'(drainLeft != 0));
        end
        if (finePass !== fineM) begin
            reportMismatch("finePass", int'(finePass), int'(fineM));
        end
        if (resultValid !== resultDue) begin
            reportMismatch("resultValid", int'(resultValid), int'(resultDue));
        end
        if (resultValid && resultDue) begin
            resCnt++;
            for (int p = 0; p < `SIFH_PIXELS; p++) begin
                if (result[p] !== stampT'(expM[p])) begin
                    reportMismatch($sformatf("result of pixel %0d", p),
                                   int'(result[p]), expM[p]);
                end
                // table value for pixels without jitter
                if (expKnown[p] && result[p] !== expResult[p]) begin
                    reportMismatch($sformatf("result of pixel %0d vs table", p),
                                   int'(result[p]), int'(expResult[p]));
                end
            end
        end
        resultDue = 1'b0;
    endtask

    //**********************************************************
    // sampling at the clock edge, values from before the edge
    //**********************************************************

    always @(posedge clk) begin
        if (!combin_res) begin
            clearModel();
            for (int p = 0; p < `SIFH_PIXELS; p++) begin
                thLowM[p] = 0;
            end
            accepted  = 0;
            drainLeft = 0;
            fineM     = 1'b0;
            resultDue = 1'b0;
        end else begin
            checkOutputs();
            if (drainLeft != 0) begin
                // strobes during drain are ignored
                drainLeft--;
                if (drainLeft == 0) begin
                    endPass();
                end
            end else if (wrEn) begin
                countSample(data);
                accepted++;
                if (accepted == SAMPLES) begin
                    accepted  = 0;
                    drainLeft = `SIFH_DRAIN;
                end
            end
        end
    end

endmodule

/* src/sifhTop.sv */
//**********************************************************
// SiFH peak finder top
//**********************************************************

`timescale 1ns/1ps

`include "sifh_params.svh"

module sifhTop import sifhPkg::*; (
    input  logic                     clk,
    input  logic                     combin_res,
    input  logic                     wrEn,
    input  stampT                    data,
    output logic                     busy,
    output logic                     finePass,
    output logic                     resultValid,
    output stampT [`SIFH_PIXELS-1:0] result
);

    // sequencer outputs
    pixT  pixel;
    passT pass;
    logic clearHist;
    logic clearPeak;
    logic latchWindow;
    logic latchResult;

    // filter to histogram
    binT  binAddr;
    logic keep;
    pixT  pixelQ;

    // histogram to peak tracker
    countT count;
    binT   bin;
    pixT   pixelOut;
    logic  hit;

    // peaks and window edges
    binT   [`SIFH_PIXELS-1:0] peakBins;
    stampT [`SIFH_PIXELS-1:0] thLowAll;

    //**********************************************************
    // control
    //**********************************************************

    frameSequencer seq_i (
        .clk         (clk),
        .combin_res  (combin_res),
        .wrEn        (wrEn),
        .pixel       (pixel),
        .pass        (pass),
        .busy        (busy),
        .clearHist   (clearHist),
        .clearPeak   (clearPeak),
        .latchWindow (latchWindow),
        .latchResult (latchResult),
        .finePass    (finePass)
    );

    //**********************************************************
    // datapath
    //**********************************************************

    sampleFilter filter_i (
        .clk        (clk),
        .combin_res (combin_res),
        .wrEn       (wrEn),
        .busy       (busy),
        .data       (data),
        .pass       (pass),
        .pixel      (pixel),
        .thLowAll   (thLowAll),
        .binAddr    (binAddr),
        .keep       (keep),
        .pixelQ     (pixelQ)
    );

    binHistogram hist_i (
        .clk        (clk),
        .combin_res (combin_res),
        .keep       (keep),
        .pixelQ     (pixelQ),
        .binAddr    (binAddr),
        .clearHist  (clearHist),
        .count      (count),
        .bin        (bin),
        .pixelOut   (pixelOut),
        .hit        (hit)
    );

    peakTracker peak_i (
        .clk        (clk),
        .combin_res (combin_res),
        .hit        (hit),
        .count      (count),
        .bin        (bin),
        .pixelOut   (pixelOut),
        .clearPeak  (clearPeak),
        .peakBins   (peakBins)
    );

    windowCalc window_i (
        .clk         (clk),
        .combin_res  (combin_res),
        .latchWindow (latchWindow),
        .latchResult (latchResult),
        .peakBins    (peakBins),
        .thLowAll    (thLowAll),
        .result      (result),
        .resultValid (resultValid)
    );

endmodule

/* src/windowCalc.sv */
//**********************************************************
// SiFH window and result
//**********************************************************

`timescale 1ns/1ps

`include "sifh_params.svh"

module windowCalc import sifhPkg::*; (
    input  logic                     clk,
    input  logic                     combin_res,
    input  logic                     latchWindow,
    input  logic                     latchResult,
    input  binT   [`SIFH_PIXELS-1:0] peakBins,
    output stampT [`SIFH_PIXELS-1:0] thLowAll,
    output stampT [`SIFH_PIXELS-1:0] result,
    output logic                     resultValid
);

    localparam int HALF   = 1 << (`SIFH_NB - 1);
    localparam int TH_MAX = (1 << `SIFH_NP) - (1 << `SIFH_NB);

    // lower window edge from a coarse peak, clamped both ways
    function automatic stampT calcThLow(binT peak);
        stampT centre;
        centre = stampT'(peak) << (`SIFH_NP - `SIFH_NB);
        if (centre < stampT'(HALF)) begin
            return '0;
        end
        if ((centre - stampT'(HALF)) > stampT'(TH_MAX)) begin
            return stampT'(TH_MAX);
        end
        return centre - stampT'(HALF);
    endfunction

    //**********************************************************
    // window latch after the coarse pass
    //**********************************************************

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            thLowAll <= '0;
        end else if (latchWindow) begin
            for (int p = 0; p < `SIFH_PIXELS; p++) begin
                thLowAll[p] <= calcThLow(peakBins[p]);
            end
        end
    end

    // fine peak is an offset, add the edge back
    always_ff @(posedge clk) begin
        if (latchResult) begin
            for (int p = 0; p < `SIFH_PIXELS; p++) begin
                result[p] <= thLowAll[p] + stampT'(peakBins[p]);
            end
        end
    end

    // one pulse per frame
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= latchResult;
        end
    end

endmodule

/* src/peakTracker.sv */
//**********************************************************
// SiFH running peak
//**********************************************************

`timescale 1ns/1ps

`include "sifh_params.svh"

module peakTracker import sifhPkg::*; (
    input  logic                   clk,
    input  logic                   combin_res,
    input  logic                   hit,
    input  countT                  count,
    input  binT                    bin,
    input  pixT                    pixelOut,
    input  logic                   clearPeak,
    output binT [`SIFH_PIXELS-1:0] peakBins
);

    // best count seen so far, per pixel
    countT bestCount [`SIFH_PIXELS];

    logic better;

    // strictly greater, ties keep the earlier bin
    assign better = hit && (count > bestCount[pixelOut]);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < `SIFH_PIXELS; p++) begin
                bestCount[p] <= '0;
            end
            peakBins <= '0;
        end else if (clearPeak) begin
            // fresh start for the next pass
            for (int p = 0; p < `SIFH_PIXELS; p++) begin
                bestCount[p] <= '0;
            end
            peakBins <= '0;
        end else if (better) begin
            bestCount[pixelOut] <= count;
            peakBins[pixelOut]  <= bin;
        end
    end

endmodule

/* src/binHistogram.sv */
//**********************************************************
// SiFH bin counters
//**********************************************************

`timescale 1ns/1ps

`include "sifh_params.svh"

module binHistogram import sifhPkg::*; (
    input  logic  clk,
    input  logic  combin_res,
    input  logic  keep,
    input  pixT   pixelQ,
    input  binT   binAddr,
    input  logic  clearHist,
    output countT count,
    output binT   bin,
    output pixT   pixelOut,
    output logic  hit
);

    localparam int IDX_W = $bits(pixT) + `SIFH_NB;
    localparam int DEPTH = `SIFH_PIXELS << `SIFH_NB;

    // one histogram per pixel, flat
    countT            hist [DEPTH];
    logic [DEPTH-1:0] binValid;

    logic [IDX_W-1:0] idx;
    countT            curCount;
    countT            nextCount;

    assign idx = {pixelQ, binAddr};

    // stale bins read as empty
    assign curCount  = binValid[idx] ? hist[idx] : '0;
    assign nextCount = curCount + 1'b1;

    //**********************************************************
    // read-increment-write
    //**********************************************************

    always_ff @(posedge clk) begin
        if (keep) begin
            hist[idx] <= nextCount;
        end
    end

    // whole-memory clear is just the valid bits
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binValid <= '0;
        end else if (clearHist) begin
            binValid <= '0;
        end else if (keep) begin
            binValid[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            hit <= 1'b0;
        end else begin
            hit <= keep;
        end
    end

    // updated count goes to the peak tracker
    always_ff @(posedge clk) begin
        count    <= nextCount;
        bin      <= binAddr;
        pixelOut <= pixelQ;
    end

endmodule

/* src/sampleFilter.sv */
//**********************************************************
// SiFH input filter
//**********************************************************

`timescale 1ns/1ps

`include "sifh_params.svh"

module sampleFilter import sifhPkg::*; (
    input  logic                          clk,
    input  logic                          combin_res,
    input  logic                          wrEn,
    input  logic                          busy,
    input  stampT                         data,
    input  passT                          pass,
    input  pixT                           pixel,
    input  stampT [`SIFH_PIXELS-1:0]      thLowAll,
    output binT                           binAddr,
    output logic                          keep,
    output pixT                           pixelQ
);

    localparam int BINS = 1 << `SIFH_NB;

    stampT thLow;
    stampT offset;
    binT   addrNext;
    logic  noPhoton;
    logic  inRange;

    always_comb begin
        // window edge of the pixel being written
        thLow    = thLowAll[pixel];
        offset   = data - thLow;
        noPhoton = &data;
        if (pass == coarsePass) begin
            // coarse bin is just the top bits
            addrNext = data[`SIFH_NP-1 -: `SIFH_NB];
            inRange  = 1'b1;
        end else begin
            // fine bin is the offset from the window edge
            addrNext = offset[`SIFH_NB-1:0];
            inRange  = (data >= thLow) && (offset < stampT'(BINS));
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            keep <= 1'b0;
        end else begin
            keep <= wrEn && !busy && !noPhoton && inRange;
        end
    end

    // address and pixel follow keep
    always_ff @(posedge clk) begin
        binAddr <= addrNext;
        pixelQ  <= pixel;
    end

endmodule

/* src/frameSequencer.sv */
//**********************************************************
// SiFH pass sequencer
//**********************************************************

`timescale 1ns/1ps

`include "sifh_params.svh"

module frameSequencer import sifhPkg::*; (
    input  logic clk,
    input  logic combin_res,
    input  logic wrEn,
    output pixT  pixel,
    output passT pass,
    output logic busy,
    output logic clearHist,
    output logic clearPeak,
    output logic latchWindow,
    output logic latchResult,
    output logic finePass
);

    localparam int SAMPLE_W = $clog2(`SIFH_DATA_NUM);
    localparam int ACQ_W    = $clog2(`SIFH_ACQ_NUM);
    localparam int DRAIN_W  = $clog2(`SIFH_DRAIN + 1);

    logic [SAMPLE_W-1:0] sampleCnt;
    logic [ACQ_W-1:0]    acqCnt;
    logic [DRAIN_W-1:0]  drainCnt;

    logic accept;
    logic lastSample;
    logic pixelWrap;
    logic sampleWrap;
    logic lastBusy;

    //**********************************************************
    // sample / pixel / acquisition counters
    //**********************************************************

    // strobes during drain are dropped
    assign accept = wrEn && !busy;

    assign sampleWrap = (sampleCnt == SAMPLE_W'(`SIFH_DATA_NUM - 1));
    assign pixelWrap  = sampleWrap && (pixel == pixT'(`SIFH_PIXELS - 1));
    // very last sample of the pass
    assign lastSample = pixelWrap && (acqCnt == ACQ_W'(`SIFH_ACQ_NUM - 1));

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            pixel     <= '0;
            acqCnt    <= '0;
        end else if (accept) begin
            // pixel-major order, all counters wrap at pass end
            sampleCnt <= sampleWrap ? '0 : sampleCnt + 1'b1;
            if (sampleWrap) begin
                pixel <= pixelWrap ? '0 : pixel + 1'b1;
            end
            if (pixelWrap) begin
                acqCnt <= lastSample ? '0 : acqCnt + 1'b1;
            end
        end
    end

    //**********************************************************
    // drain and pass toggle
    //**********************************************************

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            busy     <= 1'b0;
            drainCnt <= '0;
            pass     <= coarsePass;
        end else if (busy) begin
            if (drainCnt == '0) begin
                // drain done, next pass starts
                busy <= 1'b0;
                pass <= (pass == coarsePass) ? sifhPkg::finePass : coarsePass;
            end else begin
                drainCnt <= drainCnt - 1'b1;
            end
        end else if (accept && lastSample) begin
            busy     <= 1'b1;
            drainCnt <= DRAIN_W'(`SIFH_DRAIN - 1);
        end
    end

    // final busy cycle carries the pass-end pulses
    assign lastBusy    = busy && (drainCnt == '0);
    assign clearHist   = lastBusy;
    assign clearPeak   = lastBusy;
    assign latchWindow = lastBusy && (pass == coarsePass);
    assign latchResult = lastBusy && (pass != coarsePass);

    // observation copy of the pass
    assign finePass = (pass != coarsePass);

endmodule

/* src/sifhPkg.sv */
//**********************************************************
// SiFH shared types
//**********************************************************

`include "sifh_params.svh"

package sifhPkg;

    // which histogram pass is running
    typedef enum logic {
        coarsePass = 1'b0,
        finePass   = 1'b1
    } passT;

    // one raw timestamp
    typedef logic [`SIFH_NP-1:0] stampT;

    // one bin address, coarse top bits or fine offset
    typedef logic [`SIFH_NB-1:0] binT;

    // one bin count
    typedef logic [`SIFH_CNT_W-1:0] countT;

    // pixel index, 4 pixels
    typedef logic [1:0] pixT;

endpackage

/* src/sifh_params.svh */
//**********************************************************
// SiFH widths and counts
//**********************************************************

`ifndef SIFH_PARAMS_SVH
`define SIFH_PARAMS_SVH

// timestamp width, all-ones means no photon
`define SIFH_NP 8

// coarse bin address width, also fine window size in log2
`define SIFH_NB 4

// pixels sharing the histogram memory
`define SIFH_PIXELS 4

// samples per pixel per acquisition
`define SIFH_DATA_NUM 4

// acquisitions per pass
`define SIFH_ACQ_NUM 8

// bin count width, 32 samples per pixel per pass fit easily
`define SIFH_CNT_W 8

// cycles of busy after the last sample of a pass
`define SIFH_DRAIN 4

`endif
